// File: logic/sgb_pkg.sv
/* Shared types and constants for the console support blocks: audio samples,
   the cheat code record, download indexes and work-RAM fill bytes */

`default_nettype none

package sgb_pkg;

	// ========================================================================
	// Audio
	// ========================================================================

	typedef logic signed [15:0] sample_t;

	// ========================================================================
	// Cheat code record
	// ========================================================================

	// Half of a 32-bit field, as delivered by two download words
	typedef struct packed {
		logic [15:0] top;
		logic [15:0] bottom;
	} code_field_t;

	// Field view, most significant first
	typedef struct packed {
		code_field_t flags;
		code_field_t address;
		code_field_t compare;
		code_field_t replace;
	} code_fields_t;

	// Same 128 bits, loaded as words and consumed as fields
	typedef union packed {
		logic [7:0][15:0] words;
		code_fields_t     fields;
	} code_t;

	// Word position inside code_t for each download slot (byte offset / 2).
	// Slots run flags low, flags high, address low, address high,
	// compare low, compare high, replace low, replace high
	localparam logic [7:0][2:0] WORD_MAP = {
		3'd1, 3'd0, 3'd3, 3'd2, 3'd5, 3'd4, 3'd7, 3'd6
	};

	// Slot of the replace high word, which completes a record
	localparam logic [2:0] LAST_SLOT = 3'd7;

	// ========================================================================
	// Download indexes
	// ========================================================================

	localparam int IDX_W = 8;

	// Cartridge image, matched on the low 6 bits only
	localparam logic [IDX_W-1:0] CART_INDEX = 8'h04;
	localparam logic [IDX_W-1:0] CODE_INDEX = '1;

	// ========================================================================
	// Work-RAM fill pattern
	// ========================================================================

	localparam logic [7:0] FILL_A = 8'h66;
	localparam logic [7:0] FILL_B = 8'h99;

endpackage

`default_nettype wire

// File: logic/cheat_loader.sv
/* Cheat code loader, collects eight download words into one code record
   and strobes code_valid once the replace high word has arrived */

`timescale 1ns/1ps
`default_nettype none

module cheat_loader (
	input  wire                  clk_sys,
	input  wire                  RESET,
	input  wire                  code_wr,
	input  wire [2:0]            slot,
	input  wire [15:0]           dl_data,
	output sgb_pkg::code_t       gg_code,
	output logic                 code_valid
);

	// ========================================================================
	// Record storage
	// ========================================================================

	// Words may arrive in any order, each lands in its own slot
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			gg_code <= '0;
		end else if (code_wr) begin
			gg_code.words[sgb_pkg::WORD_MAP[slot]] <= dl_data;
		end
	end

	// ========================================================================
	// Completion strobe
	// ========================================================================

	// One cycle after the replace high word, record is then whole
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_valid <= 1'b0;
		end else begin
			code_valid <= code_wr && (slot == sgb_pkg::LAST_SLOT);
		end
	end

endmodule

`default_nettype wire

// File: logic/ram_clear.sv
/* Work-RAM clear engine, walks the whole address space once per cartridge
   download and writes the two-value checker pattern */

`timescale 1ns/1ps
`default_nettype none

module ram_clear #(
	// Pattern uses address bits 8 and 2, so at least 9
	parameter int FILL_ADDR_W = 17
) (
	input  wire                    clk_sys,
	input  wire                    RESET,
	input  wire                    cart_dl,
	output logic                   clearing,
	output logic [FILL_ADDR_W-1:0] fill_addr,
	output logic [7:0]             fill_data,
	output logic                   fill_wr
);

	logic cart_dl_q;
	logic cart_rise;

	// Start on the leading edge of the download level only
	assign cart_rise = cart_dl & ~cart_dl_q;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q <= 1'b0;
			clearing  <= 1'b0;
			fill_addr <= '0;
		end else begin
			cart_dl_q <= cart_dl;

			if (clearing) begin
				// Last address written this cycle
				if (&fill_addr) begin
					clearing <= 1'b0;
				end
				fill_addr <= fill_addr + 1'b1;
			end else begin
				// An edge seen mid-walk is dropped
				if (cart_rise) begin
					clearing <= 1'b1;
				end
				fill_addr <= '0;
			end
		end
	end

	// One write per cycle for the whole walk
	assign fill_wr = clearing;

	// Checker pattern
	assign fill_data = (fill_addr[8] ^ fill_addr[2]) ? sgb_pkg::FILL_A : sgb_pkg::FILL_B;

endmodule

`default_nettype wire

// File: logic/audio_mix.sv
/* Audio mixer, adds the handheld sound and optionally the streamed
   soundtrack to the main sound, with a registered output and mute */

`timescale 1ns/1ps
`default_nettype none

module audio_mix (
	input  wire                  clk_sys,
	input  wire                  RESET,
	input  sgb_pkg::sample_t     main_l,
	input  sgb_pkg::sample_t     main_r,
	input  sgb_pkg::sample_t     gb_l,
	input  sgb_pkg::sample_t     gb_r,
	input  sgb_pkg::sample_t     msu_l,
	input  sgb_pkg::sample_t     msu_r,
	input  wire                  msu_en,
	input  wire                  mute,
	output sgb_pkg::sample_t     audio_l,
	output sgb_pkg::sample_t     audio_r
);

	// One channel of the mix, identical for left and right
	function automatic sgb_pkg::sample_t mix_channel(
		input sgb_pkg::sample_t main_s,
		input sgb_pkg::sample_t gb_s,
		input sgb_pkg::sample_t msu_s,
		input logic             use_msu
	);
		logic [15:0] gb_scaled;
		logic [16:0] sum_s;
		logic [16:0] sum_t;
		gb_scaled = {gb_s[15], gb_s[13:0], 1'b0};
		// 17 bits so the first add cannot overflow
		sum_s = {main_s[15], main_s} + {gb_scaled[15], gb_scaled};
		// Soundtrack at half level, sign kept
		sum_t = {sum_s[16], sum_s[16:1]} + {msu_s[15], msu_s[15], msu_s[15:1]};
		if (use_msu) begin
			return sum_t[16:1];
		end
		return sum_s[16:1];
	endfunction

	// ========================================================================
	// Output register
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			audio_l <= '0;
			audio_r <= '0;
		end else if (mute) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= mix_channel(main_l, gb_l, msu_l, msu_en);
			audio_r <= mix_channel(main_r, gb_r, msu_r, msu_en);
		end
	end

endmodule

`default_nettype wire

// File: logic/sgb_support.sv
/* Console support top level, decodes the download index and hosts the
   cheat loader, the work-RAM clear engine and the audio mixer */

`timescale 1ns/1ps
`default_nettype none

module sgb_support #(
	parameter int FILL_ADDR_W = 17
) (
	input  wire                       clk_sys,
	input  wire                       RESET,

	// Download port
	input  wire                       dl_active,
	input  wire [sgb_pkg::IDX_W-1:0]  dl_index,
	input  wire [15:0]                dl_addr,
	input  wire [15:0]                dl_data,
	input  wire                       dl_wr,

	// Audio sources and controls
	input  sgb_pkg::sample_t          main_l,
	input  sgb_pkg::sample_t          main_r,
	input  sgb_pkg::sample_t          gb_l,
	input  sgb_pkg::sample_t          gb_r,
	input  sgb_pkg::sample_t          msu_l,
	input  sgb_pkg::sample_t          msu_r,
	input  wire                       msu_en,
	input  wire                       mute,

	// Cheat record
	output sgb_pkg::code_t            gg_code,
	output logic                      code_valid,

	// Work-RAM clear, clearing also holds the system in reset
	output logic                      clearing,
	output logic [FILL_ADDR_W-1:0]    fill_addr,
	output logic [7:0]                fill_data,
	output logic                      fill_wr,

	output sgb_pkg::sample_t          audio_l,
	output sgb_pkg::sample_t          audio_r
);

	logic code_wr;
	logic cart_dl;

	// ========================================================================
	// Download index decode
	// ========================================================================

	assign code_wr = dl_active & dl_wr & (dl_index == sgb_pkg::CODE_INDEX);
	// Upper index bits select cartridge variants, not checked here
	assign cart_dl = dl_active & (dl_index[5:0] == sgb_pkg::CART_INDEX[5:0]);

	// ========================================================================
	// Blocks
	// ========================================================================

	cheat_loader u_cheat_loader (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.code_wr    (code_wr),
		.slot       (dl_addr[3:1]),
		.dl_data    (dl_data),
		.gg_code    (gg_code),
		.code_valid (code_valid)
	);

	ram_clear #(
		.FILL_ADDR_W (FILL_ADDR_W)
	) u_ram_clear (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.cart_dl   (cart_dl),
		.clearing  (clearing),
		.fill_addr (fill_addr),
		.fill_data (fill_data),
		.fill_wr   (fill_wr)
	);

	audio_mix u_audio_mix (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.main_l  (main_l),
		.main_r  (main_r),
		.gb_l    (gb_l),
		.gb_r    (gb_r),
		.msu_l   (msu_l),
		.msu_r   (msu_r),
		.msu_en  (msu_en),
		.mute    (mute),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

endmodule

`default_nettype wire

// File: verif/sgb_support_chk.sv
/* Protocol checks on the support top level, bound into the design */

`timescale 1ns/1ps
`default_nettype none

module sgb_support_chk #(
	parameter int FILL_ADDR_W = 17
) (
	input wire                   clk_sys,
	input wire                   RESET,
	input wire                   code_valid,
	input wire                   clearing,
	input wire [FILL_ADDR_W-1:0] fill_addr
);

	// Strobe is a single cycle
	a_valid_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid)
		else $error("code_valid high for two cycles");

	// Walk ends one cycle after the last address
	a_walk_end: assert property (@(posedge clk_sys) disable iff (RESET)
		(clearing && (&fill_addr)) |=> !clearing)
		else $error("clearing held past the last address");

	// Address walk steps by one
	a_addr_step: assert property (@(posedge clk_sys) disable iff (RESET)
		(clearing && $past(clearing)) |-> (fill_addr == FILL_ADDR_W'($past(fill_addr) + 1'b1)))
		else $error("fill_addr did not advance by one");

endmodule

bind sgb_support sgb_support_chk #(
	.FILL_ADDR_W (FILL_ADDR_W)
) u_chk (
	.clk_sys    (clk_sys),
	.RESET      (RESET),
	.code_valid (code_valid),
	.clearing   (clearing),
	.fill_addr  (fill_addr)
);

`default_nettype wire

// File: verif/tb_sgb_support.sv
/* Testbench for the console support top level, plays the case file through
   the cheat loader, the audio mixer and the work-RAM clear engine */

`timescale 1ns/1ps
`default_nettype none

module tb_sgb_support;

	localparam int FILL_W    = 10;
	localparam int ROW_W     = 13;
	localparam int MAX_ROWS  = 32;
	localparam int DRIVE_DLY = 2;

	logic                      clk_sys;
	logic                      RESET;
	logic                      dl_active;
	logic [sgb_pkg::IDX_W-1:0] dl_index;
	logic [15:0]               dl_addr;
	logic [15:0]               dl_data;
	logic                      dl_wr;
	sgb_pkg::sample_t          main_l;
	sgb_pkg::sample_t          main_r;
	sgb_pkg::sample_t          gb_l;
	sgb_pkg::sample_t          gb_r;
	sgb_pkg::sample_t          msu_l;
	sgb_pkg::sample_t          msu_r;
	logic                      msu_en;
	logic                      mute;
	sgb_pkg::code_t            gg_code;
	logic                      code_valid;
	logic                      clearing;
	logic [FILL_W-1:0]         fill_addr;
	logic [7:0]                fill_data;
	logic                      fill_wr;
	sgb_pkg::sample_t          audio_l;
	sgb_pkg::sample_t          audio_r;

	logic [31:0]    cases [0:ROW_W*MAX_ROWS-1];
	sgb_pkg::code_t last_code;
	integer         seed;
	int             row_count;
	int             watchdog_cycles = 0;

	sgb_support #(.FILL_ADDR_W(FILL_W)) u_dut (.*);

	always #20 clk_sys = ~clk_sys;

	// ========================================================================
	// Failure handling and compares
	// ========================================================================

	task automatic stop_on_failure();
		$display("TB FAILED");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("ERROR at %0t: %s expected %h got %h", $time, name, want, got);
			stop_on_failure();
		end
	endtask

	task automatic check_code(input string name, input sgb_pkg::code_t got,
			input sgb_pkg::code_t want);
		if (got !== want) begin
			$display("ERROR at %0t: %s expected %h got %h", $time, name, want, got);
			stop_on_failure();
		end
	endtask

	task automatic check_sample(input string name, input sgb_pkg::sample_t got,
			input sgb_pkg::sample_t want);
		if (got !== want) begin
			$display("ERROR at %0t: %s expected %h got %h", $time, name, want, got);
			stop_on_failure();
		end
	endtask

	task automatic check_fill(input string name, input logic [7:0] got, input logic [7:0] want);
		if (got !== want) begin
			$display("ERROR at %0t: %s expected %h got %h", $time, name, want, got);
			stop_on_failure();
		end
	endtask

	task automatic check_addr(input string name, input logic [FILL_W-1:0] got,
			input logic [FILL_W-1:0] want);
		if (got !== want) begin
			$display("ERROR at %0t: %s expected %h got %h", $time, name, want, got);
			stop_on_failure();
		end
	endtask

	// ========================================================================
	// Reference mixer and helpers
	// ========================================================================

	// Integer form of the mix, halvings as arithmetic shifts
	function automatic sgb_pkg::sample_t mix_expect(input sgb_pkg::sample_t m,
			input sgb_pkg::sample_t g, input sgb_pkg::sample_t s, input logic en, input logic mu);
		logic [15:0]      g_bits;
		int               sum_s;
		int               sum_t;
		sgb_pkg::sample_t result;
		g_bits = {g[15], g[13:0], 1'b0};
		sum_s  = int'(m) + int'($signed(g_bits));
		sum_t  = (sum_s >>> 1) + (int'(s) >>> 1);
		if (mu) begin
			result = '0;
		end else if (en) begin
			result = sgb_pkg::sample_t'(sum_t >>> 1);
		end else begin
			result = sgb_pkg::sample_t'(sum_s >>> 1);
		end
		return result;
	endfunction

	// Shuffled write order, replace high stays last
	function automatic int slot_for_step(input int k);
		case (k)
			0: return 5;
			1: return 2;
			2: return 0;
			3: return 6;
			4: return 3;
			5: return 1;
			6: return 4;
			default: return 7;
		endcase
	endfunction

	task automatic next_cycle();
		@(posedge clk_sys);
		#DRIVE_DLY;
	endtask

	// ========================================================================
	// Row players
	// ========================================================================

	task automatic load_code(input int base);
		int             k;
		int             slot;
		sgb_pkg::code_t want;
		want.fields.flags   = cases[base+9];
		want.fields.address = cases[base+10];
		want.fields.compare = cases[base+11];
		want.fields.replace = cases[base+12];
		for (k = 0; k < 8; k++) begin
			next_cycle();
			check_bit("code_valid", code_valid, 1'b0);
			slot      = slot_for_step(k);
			dl_active = 1'b1;
			dl_index  = 8'hFF;
			// Odd byte offsets on every other word
			dl_addr   = 16'(slot * 2 + (k & 1));
			dl_data   = cases[base+1+slot][15:0];
			dl_wr     = 1'b1;
		end
		next_cycle();
		check_bit("code_valid", code_valid, 1'b1);
		check_code("gg_code", gg_code, want);
		dl_wr     = 1'b0;
		dl_active = 1'b0;
		next_cycle();
		check_bit("code_valid", code_valid, 1'b0);
		last_code = want;
	endtask

	task automatic write_ignored(input logic [7:0] index, input logic active);
		int k;
		for (k = 0; k < 8; k++) begin
			next_cycle();
			check_bit("code_valid", code_valid, 1'b0);
			dl_active = active;
			dl_index  = index;
			dl_addr   = 16'(k * 2);
			dl_data   = 16'hBAD0 | 16'(k);
			dl_wr     = 1'b1;
		end
		next_cycle();
		dl_wr     = 1'b0;
		dl_active = 1'b0;
		check_bit("code_valid", code_valid, 1'b0);
		check_code("gg_code", gg_code, last_code);
	endtask

	task automatic play_audio(input int base);
		next_cycle();
		main_l = cases[base+1][15:0];
		main_r = cases[base+2][15:0];
		gb_l   = cases[base+3][15:0];
		gb_r   = cases[base+4][15:0];
		msu_l  = cases[base+5][15:0];
		msu_r  = cases[base+6][15:0];
		msu_en = cases[base+7][0];
		mute   = cases[base+8][0];
		next_cycle();
		check_sample("audio_l", audio_l, cases[base+9][15:0]);
		check_sample("audio_r", audio_r, cases[base+10][15:0]);
	endtask

	task automatic play_random(input int count);
		int          n;
		logic [31:0] r;
		for (n = 0; n < count; n++) begin
			next_cycle();
			r = $random(seed);
			main_l = r[15:0];
			main_r = r[31:16];
			r = $random(seed);
			gb_l = r[15:0];
			gb_r = r[31:16];
			r = $random(seed);
			msu_l = r[15:0];
			msu_r = r[31:16];
			r = $random(seed);
			msu_en = r[0];
			mute   = (r[3:1] == 3'd0);
			next_cycle();
			check_sample("audio_l", audio_l, mix_expect(main_l, gb_l, msu_l, msu_en, mute));
			check_sample("audio_r", audio_r, mix_expect(main_r, gb_r, msu_r, msu_en, mute));
		end
		mute = 1'b0;
	endtask

	task automatic run_clear(input logic [7:0] index);
		int         a;
		logic [7:0] want_data;
		next_cycle();
		dl_active = 1'b1;
		dl_index  = index;
		next_cycle();
		check_bit("clearing", clearing, 1'b1);
		for (a = 0; a < (1 << FILL_W); a++) begin
			check_bit("fill_wr", fill_wr, 1'b1);
			check_addr("fill_addr", fill_addr, FILL_W'(a));
			want_data = ((((a >> 8) ^ (a >> 2)) & 1) != 0) ? 8'h66 : 8'h99;
			check_fill("fill_data", fill_data, want_data);
			// Second rising edge in mid walk
			if (a == 500) dl_active = 1'b0;
			if (a == 502) dl_active = 1'b1;
			next_cycle();
		end
		check_bit("clearing", clearing, 1'b0);
		// Level still held, no new walk
		repeat (8) begin
			next_cycle();
			check_bit("clearing", clearing, 1'b0);
			check_bit("fill_wr", fill_wr, 1'b0);
		end
		dl_active = 1'b0;
	endtask

	// ========================================================================
	// Main sequence and watchdog
	// ========================================================================

	initial begin
		int row;
		int base;
		clk_sys   = 1'b0;
		RESET     = 1'b1;
		dl_active = 1'b0;
		dl_index  = '0;
		dl_addr   = '0;
		dl_data   = '0;
		dl_wr     = 1'b0;
		main_l    = '0;
		main_r    = '0;
		gb_l      = '0;
		gb_r      = '0;
		msu_l     = '0;
		msu_r     = '0;
		msu_en    = 1'b0;
		mute      = 1'b0;
		last_code = '0;
		seed      = 82452;
		$readmemh("verif/sgb_cases.txt", cases);
		row_count = 0;
		while (row_count < MAX_ROWS && cases[row_count*ROW_W] != 32'hF) begin
			row_count++;
		end
		if (row_count == MAX_ROWS) begin
			$display("The case file has no end row");
			stop_on_failure();
		end
		watchdog_cycles = row_count * (1 << FILL_W) + 100;

		repeat (2) @(posedge clk_sys);
		#DRIVE_DLY;
		RESET = 1'b0;
		next_cycle();
		check_bit("code_valid", code_valid, 1'b0);
		check_bit("clearing", clearing, 1'b0);
		check_bit("fill_wr", fill_wr, 1'b0);
		check_sample("audio_l", audio_l, '0);
		check_sample("audio_r", audio_r, '0);
		check_code("gg_code", gg_code, '0);

		for (row = 0; row < row_count; row++) begin
			base = row * ROW_W;
			case (cases[base])
				32'h1: load_code(base);
				32'h2: play_audio(base);
				32'h3: play_random(int'(cases[base+1]));
				32'h4: write_ignored(cases[base+1][7:0], cases[base+2][0]);
				32'h5: run_clear(cases[base+1][7:0]);
				default: begin
					$display("Unknown row type %h in case row %0d", cases[base], row);
					stop_on_failure();
				end
			endcase
		end

		$display("TB PASSED");
		$finish;
	end

	initial begin
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge clk_sys);
		$display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
		stop_on_failure();
	end

endmodule

`default_nettype wire

// File: verif/sgb_cases.txt
// Rows of 13 hex words, tag first, unused words zero. 1 cheat: 8 words by offset, then
// flags address compare replace. 2 audio: main l r, gb l r, msu l r, msu_en, mute, exp l r
// 3 random audio: count. 4 ignored write: index, active. 5 clear: index. f end
// Cheat records, the second overwrites every field
1 1111 2222 3333 4444 5555 6666 7777 8888
  22221111 44443333 66665555 88887777
1 a001 b002 c003 d004 e005 f006 0107 0208
  b002a001 d004c003 f006e005 02080107
// Wrong index, then inactive download
4 fe 1 0 0 0 0 0 0 0 0 0 0
4 ff 0 0 0 0 0 0 0 0 0 0 0
// Fixed audio rows
2 0000 0000 0000 0000 0000 0000 0 0 0000 0000 0 0
2 1000 2000 0400 0100 1234 1234 0 0 0c00 1100 0 0
2 8000 8000 8000 ffff 0000 0000 0 0 8000 bfff 0 0
2 8000 7fff 8000 3fff 8000 7fff 1 0 a000 5ffe 0 0
2 0000 0000 4001 7000 0000 0000 0 0 0001 3000 0 0
2 0100 ff00 0000 fffe 0200 ffff 1 0 00c0 ffbe 0 0
2 1234 8000 7fff 8000 4000 8000 1 1 0000 0000 0 0
// Random mix rows
3 40 0 0 0 0 0 0 0 0 0 0 0
// Cartridge downloads, upper index bits are not decoded
5 04 0 0 0 0 0 0 0 0 0 0 0
5 44 0 0 0 0 0 0 0 0 0 0 0
// End of cases
f 0 0 0 0 0 0 0 0 0 0 0 0

// File: list.f
logic/sgb_pkg.sv
logic/cheat_loader.sv
logic/ram_clear.sv
logic/audio_mix.sv
logic/sgb_support.sv
verif/sgb_support_chk.sv
verif/tb_sgb_support.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_sgb_support
FILELIST  := list.f

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
